//--- rtl/memSysPkg.sv
package memSysPkg;

	// request operation codes
	typedef enum logic [2:0]
	{
		opmReady     = 3'd0,	// idle port
		opmLoadWord  = 3'd1,	// 32-bit load
		opmStoreWord = 3'd2,	// 32-bit store
		opmFetchHalf = 3'd3,	// instruction halfword
		opmLineRead  = 3'd4,	// 16-byte line read
		opmLineWrite = 3'd5	// 16-byte line write
	} memOpm_e;

	// response status
	typedef enum logic [1:0]
	{
		okReady = 2'd0,	// nothing requested
		okOk    = 2'd1,	// done this cycle
		okHold  = 2'd2,	// wait, keep request stable
		okFault = 2'd3	// misaligned or bad op
	} memOk_e;

	// one line, two views
	typedef union packed
	{
		logic [3:0][31:0] words;	// data cache view
		logic [7:0][15:0] halves;	// instruction cache view
	} memLine_u;

	typedef struct packed
	{
		memOpm_e     opm;
		logic [31:0] addr;	// byte address
		logic [31:0] data;	// store data
	} dataReq_s;

	typedef struct packed
	{
		memOk_e      ok;
		logic [31:0] data;	// load data
	} dataResp_s;

	typedef struct packed
	{
		memOk_e      ok;
		logic [15:0] val;	// fetched halfword
	} fetchResp_s;

	typedef struct packed
	{
		memOpm_e     opm;
		logic [27:0] addr;	// line address, byte address >> 4
		memLine_u    data;	// write data
	} lineReq_s;

	typedef struct packed
	{
		memOk_e   ok;
		memLine_u data;	// read data
	} lineResp_s;

	// power-on value of the word at a byte address
	function automatic logic [31:0] initWord(input logic [31:0] byteAddr);
		return byteAddr ^ 32'h5A5A0000;
	endfunction

	// whole line built from initWord, word 0 at the lowest address
	function automatic memLine_u initLine(input logic [27:0] lineAddr);
		memLine_u line;
		for (int w = 0; w < 4; w++)
		begin
			line.words[w] = initWord({lineAddr, 2'(w), 2'b00});
		end
		return line;
	endfunction

endpackage

//--- rtl/instCache.sv
`timescale 1ns/100ps

module instCache #(
	parameter int numLines = 16	// power of two
) (
	input  logic                  clock,
	input  logic                  rst,
	input  logic [31:0]           fetchPc,	// zero parks the port
	output memSysPkg::fetchResp_s fetchResp,
	output memSysPkg::lineReq_s   lineReq,
	input  memSysPkg::lineResp_s  lineResp
);
	import memSysPkg::*;

	localparam int idxW = $clog2(numLines);
	localparam int tagW = 28 - idxW;

	logic [numLines-1:0] valid;	// per-line valid bits
	logic [tagW-1:0]     tags [numLines];	// tag flops
	memLine_u            lineData [numLines];	// line flops

	logic [27:0]     lineAddr;
	logic [idxW-1:0] idx;
	logic [tagW-1:0] tag;
	logic            idle;
	logic            hit;
	logic            fillDone;
	memLine_u        curLine;

	assign lineAddr = fetchPc[31:4];
	assign idx      = lineAddr[idxW-1:0];	// low line bits pick the slot
	assign tag      = lineAddr[27:idxW];
	assign idle     = fetchPc == 32'h0;	// no fetch this cycle
	assign curLine  = lineData[idx];	// combinational read
	assign hit      = valid[idx] && (tags[idx] == tag);

	// line has come back from the arbiter
	assign fillDone = (lineReq.opm == opmLineRead) && (lineResp.ok == okOk);

	always_comb
	begin
		fetchResp.val = curLine.halves[fetchPc[3:1]];	// halfword view
		lineReq.opm   = opmReady;
		lineReq.addr  = lineAddr;
		lineReq.data  = '0;	// reads carry no data
		if (idle)
			fetchResp.ok = okReady;
		else if (fetchPc[0])
			fetchResp.ok = okFault;	// odd pc
		else if (hit)
			fetchResp.ok = okOk;	// same-cycle hit
		else
		begin
			fetchResp.ok = okHold;	// miss, go get the line
			lineReq.opm  = opmLineRead;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			valid <= '0;
		end
		else if (fillDone)
		begin
			valid[idx] <= 1'b1;	// hit follows next cycle
		end
	end

	// arrays keep whatever they held until a fill lands
	always_ff @(posedge clock)
	begin
		if (fillDone)
		begin
			tags[idx]     <= tag;
			lineData[idx] <= lineResp.data;
		end
	end

	// a stalled fetch must keep its pc until the hold clears
	pcStableOnHold: assert property (@(posedge clock) disable iff (rst)
		fetchResp.ok == okHold |=> $stable(fetchPc))
		else $error("instCache: fetch pc changed during hold");

endmodule

//--- rtl/dataCache.sv
`timescale 1ns/100ps

module dataCache #(
	parameter int numLines = 16	// power of two
) (
	input  logic                 clock,
	input  logic                 rst,
	input  memSysPkg::dataReq_s  dReq,
	output memSysPkg::dataResp_s dResp,
	output memSysPkg::lineReq_s  lineReq,
	input  memSysPkg::lineResp_s lineResp
);
	import memSysPkg::*;

	localparam int idxW = $clog2(numLines);
	localparam int tagW = 28 - idxW;

	localparam logic [1:0] sIdle  = 2'd0;	// decode request
	localparam logic [1:0] sFill  = 2'd1;	// line read in flight
	localparam logic [1:0] sWrite = 2'd2;	// write-through in flight
	localparam logic [1:0] sDone  = 2'd3;	// store OK for one cycle

	logic [1:0] state;
	logic [1:0] nextState;

	logic [numLines-1:0] valid;
	logic [tagW-1:0]     tags [numLines];
	memLine_u            lineData [numLines];

	logic [27:0]     lineAddr;
	logic [idxW-1:0] idx;
	logic [tagW-1:0] tag;
	logic            isLoad;
	logic            isStore;
	logic            misaligned;
	logic            hit;
	logic            lineOk;
	memLine_u        curLine;
	memLine_u        mergedLine;

	assign lineAddr   = dReq.addr[31:4];
	assign idx        = lineAddr[idxW-1:0];
	assign tag        = lineAddr[27:idxW];
	assign isLoad     = dReq.opm == opmLoadWord;
	assign isStore    = dReq.opm == opmStoreWord;
	assign misaligned = dReq.addr[1:0] != 2'b00;	// words only
	assign curLine    = lineData[idx];
	assign hit        = valid[idx] && (tags[idx] == tag);
	assign lineOk     = lineResp.ok == okOk;

	// store word dropped into the cached line, word view
	always_comb
	begin
		mergedLine = curLine;
		mergedLine.words[dReq.addr[3:2]] = dReq.data;
	end

	always_comb
	begin
		nextState    = state;
		dResp.ok     = okReady;
		dResp.data   = curLine.words[dReq.addr[3:2]];	// stored word after sDone
		lineReq.opm  = opmReady;
		lineReq.addr = lineAddr;
		lineReq.data = mergedLine;	// only looked at on writes
		case (state)
			sIdle:
			begin
				if (dReq.opm == opmReady)
					dResp.ok = okReady;
				else if (!(isLoad || isStore) || misaligned)
					dResp.ok = okFault;	// no line traffic
				else if (!hit)
				begin
					dResp.ok  = okHold;	// allocate on load or store
					nextState = sFill;
				end
				else if (isStore)
				begin
					dResp.ok  = okHold;
					nextState = sWrite;
				end
				else
					dResp.ok = okOk;	// load hit
			end
			sFill:
			begin
				dResp.ok    = okHold;
				lineReq.opm = opmLineRead;
				if (lineOk)
					nextState = sIdle;	// request now hits
			end
			sWrite:
			begin
				dResp.ok    = okHold;
				lineReq.opm = opmLineWrite;	// full merged line
				if (lineOk)
					nextState = sDone;
			end
			default:
			begin
				dResp.ok  = okOk;	// store complete
				nextState = sIdle;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= sIdle;
			valid <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == sFill && lineOk)
				valid[idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == sFill && lineOk)
		begin
			tags[idx]     <= tag;
			lineData[idx] <= lineResp.data;	// fresh line from memory
		end
		else if (state == sWrite && lineOk)
		begin
			lineData[idx] <= mergedLine;	// cache matches memory again
		end
	end

	// whole request held while stalled, fill and write both depend on it
	reqStableOnHold: assert property (@(posedge clock) disable iff (rst)
		dResp.ok == okHold |=> $stable(dReq))
		else $error("dataCache: request changed during hold");

endmodule

//--- rtl/lineArbiter.sv
`timescale 1ns/100ps

module lineArbiter (
	input  logic                 clock,
	input  logic                 rst,
	input  memSysPkg::lineReq_s  iLineReq,
	input  memSysPkg::lineReq_s  dLineReq,
	output memSysPkg::lineResp_s iLineResp,
	output memSysPkg::lineResp_s dLineResp,
	output memSysPkg::lineReq_s  memReq,
	input  memSysPkg::lineResp_s memResp
);
	import memSysPkg::*;

	localparam logic [1:0] ownNone = 2'd0;
	localparam logic [1:0] ownInst = 2'd1;
	localparam logic [1:0] ownData = 2'd2;

	logic [1:0] owner;	// side holding the memory
	logic       iWants;
	logic       dWants;
	logic       grantI;
	logic       grantD;

	assign iWants = iLineReq.opm != opmReady;
	assign dWants = dLineReq.opm != opmReady;

	always_comb
	begin
		grantI = 1'b0;
		grantD = 1'b0;
		case (owner)
			ownInst: grantI = 1'b1;	// keep transfer going
			ownData: grantD = 1'b1;
			default:
			begin
				grantI = iWants;	// instruction side first
				grantD = !iWants && dWants;
			end
		endcase
	end

	always_comb
	begin
		memReq = '0;	// opm ready when nobody granted
		if (grantI)
			memReq = iLineReq;
		else if (grantD)
			memReq = dLineReq;
		iLineResp.data = memResp.data;
		dLineResp.data = memResp.data;
		iLineResp.ok   = grantI ? memResp.ok : (iWants ? okHold : okReady);
		dLineResp.ok   = grantD ? memResp.ok : (dWants ? okHold : okReady);
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			owner <= ownNone;
		else if (memResp.ok != okHold)
			owner <= ownNone;	// done or idle frees the port
		else if (grantI)
			owner <= ownInst;
		else if (grantD)
			owner <= ownData;
	end

	// a transfer the memory is still holding keeps its request unchanged
	transferHeldToOk: assert property (@(posedge clock) disable iff (rst)
		memResp.ok == okHold |=> $stable(memReq))
		else $error("lineArbiter: memory request changed before its OK");

endmodule

//--- rtl/lineMemory.sv
`timescale 1ns/100ps

module lineMemory #(
	parameter int memLines   = 256,	// power of two
	parameter int memLatency = 3	// at least 1
) (
	input  logic                 clock,
	input  logic                 rst,
	input  memSysPkg::lineReq_s  lineReq,
	output memSysPkg::lineResp_s lineResp
);
	import memSysPkg::*;

	localparam int idxW = $clog2(memLines);
	localparam int cntW = $clog2(memLatency + 1);

	memLine_u            lines [memLines];	// stored lines
	logic [memLines-1:0] written;	// line holds stored data

	logic            busy;	// request being counted
	logic [cntW-1:0] count;	// cycles left
	logic            active;
	logic            done;
	logic [idxW-1:0] idx;
	memLine_u        readLine;

	assign active = (lineReq.opm == opmLineRead) || (lineReq.opm == opmLineWrite);
	assign done   = busy && (count == '0);
	assign idx    = lineReq.addr[idxW-1:0];	// higher lines alias

	// unwritten lines read back their power-on pattern
	assign readLine = written[idx] ? lines[idx] : initLine(lineReq.addr);

	always_comb
	begin
		lineResp.data = readLine;
		if (lineReq.opm == opmReady)
			lineResp.ok = okReady;
		else if (!active)
			lineResp.ok = okFault;	// word ops do not belong here
		else if (done)
			lineResp.ok = okOk;
		else
			lineResp.ok = okHold;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			busy    <= 1'b0;
			count   <= '0;
			written <= '0;	// everything back to initWord
		end
		else
		begin
			if (!active || done)
				busy <= 1'b0;	// ready for the next request
			else if (!busy)
			begin
				busy  <= 1'b1;	// first cycle of a request
				count <= cntW'(memLatency - 1);
			end
			else
				count <= count - cntW'(1);
			if (done && lineReq.opm == opmLineWrite)
				written[idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (done && lineReq.opm == opmLineWrite)
			lines[idx] <= lineReq.data;	// write lands with its OK
	end

endmodule

//--- rtl/memSubsys.sv
`timescale 1ns/100ps

module memSubsys #(
	parameter int numLines   = 16,	// lines per cache
	parameter int memLines   = 256,	// backing store lines
	parameter int memLatency = 3	// memory wait cycles
) (
	input  logic                  clock,
	input  logic                  rst,
	input  memSysPkg::dataReq_s   dReq,
	output memSysPkg::dataResp_s  dResp,
	input  logic [31:0]           fetchPc,
	output memSysPkg::fetchResp_s fetchResp
);
	import memSysPkg::*;

	lineReq_s  iLineReq;	// instruction cache to arbiter
	lineResp_s iLineResp;
	lineReq_s  dLineReq;	// data cache to arbiter
	lineResp_s dLineResp;
	lineReq_s  memReq;	// arbiter to memory
	lineResp_s memResp;

	instCache #(.numLines(numLines)) u_instCache (
		.clock     (clock),
		.rst       (rst),
		.fetchPc   (fetchPc),
		.fetchResp (fetchResp),
		.lineReq   (iLineReq),
		.lineResp  (iLineResp)
	);

	dataCache #(.numLines(numLines)) u_dataCache (
		.clock    (clock),
		.rst      (rst),
		.dReq     (dReq),
		.dResp    (dResp),
		.lineReq  (dLineReq),
		.lineResp (dLineResp)
	);

	lineArbiter u_lineArbiter (
		.clock     (clock),
		.rst       (rst),
		.iLineReq  (iLineReq),
		.dLineReq  (dLineReq),
		.iLineResp (iLineResp),
		.dLineResp (dLineResp),
		.memReq    (memReq),
		.memResp   (memResp)
	);

	lineMemory #(
		.memLines   (memLines),
		.memLatency (memLatency)
	) u_lineMemory (
		.clock    (clock),
		.rst      (rst),
		.lineReq  (memReq),
		.lineResp (memResp)
	);

endmodule

//--- dv/clockGen.sv
`timescale 1ns/100ps

module clockGen (
	output logic clock,
	output logic rst
);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;	// 4 ns period
	end

	initial
	begin
		rst = 1'b1;	// held over the first three edges
		repeat (3) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;	// released away from the active edge
	end

endmodule

//--- dv/memChecker.sv
`timescale 1ns/100ps

module memChecker (
	input  logic                  clock,
	input  logic                  rst,
	input  memSysPkg::dataResp_s  dResp,
	input  memSysPkg::fetchResp_s fetchResp,
	input  logic                  dArmed,	// data test in flight
	input  memSysPkg::dataResp_s  dExp,
	input  logic                  dMustHit,	// answer due in the first cycle
	input  int                    dTestNum,
	input  logic                  fArmed,	// fetch test in flight
	input  memSysPkg::fetchResp_s fExp,
	input  logic                  fMustHit,
	input  int                    fTestNum,
	output int                    passCount,
	output int                    failCount
);
	import memSysPkg::*;

	int dWait;	// hold cycles seen on the data port
	int fWait;	// same for the fetch port

	// one verdict line per finished test
	task automatic judge(input string port, input int num, input memOk_e gotOk,
		input memOk_e expOk, input logic [31:0] got, input logic [31:0] exp,
		input logic mustHit, input int waited);
		if (gotOk != expOk)
		begin
			$display("FAIL %0t: test %0d %s port status %s, expected %s",
				$time, num, port, gotOk.name(), expOk.name());
			failCount++;
		end
		else if (gotOk == okOk && got != exp)
		begin
			$display("FAIL %0t: test %0d %s port returned %h, expected %h",
				$time, num, port, got, exp);
			failCount++;
		end
		else if (mustHit && waited != 0)
		begin
			$display("FAIL %0t: test %0d %s port waited %0d cycles, expected none",
				$time, num, port, waited);
			failCount++;
		end
		else
		begin
			$display("ok   test %0d %s port %s value %h after %0d waits",
				num, port, gotOk.name(), got, waited);
			passCount++;
		end
	endtask

	always @(posedge clock)
	begin
		if (rst)
		begin
			passCount = 0;
			failCount = 0;
			dWait     = 0;
			fWait     = 0;
		end
		else
		begin
			if (dArmed)
			begin
				if (dResp.ok == okHold)
					dWait++;	// still stalled
				else
				begin
					judge("data", dTestNum, dResp.ok, dExp.ok, dResp.data, dExp.data,
						dMustHit, dWait);
					dWait = 0;
				end
			end
			if (fArmed)
			begin
				if (fetchResp.ok == okHold)
					fWait++;
				else
				begin
					judge("fetch", fTestNum, fetchResp.ok, fExp.ok, {16'h0, fetchResp.val},
						{16'h0, fExp.val}, fMustHit, fWait);
					fWait = 0;
				end
			end
		end
	end

endmodule

//--- dv/memSubsysTb.sv
`timescale 1ns/100ps

module memSubsysTb;
	import memSysPkg::*;

	localparam int waitLimit = 100;	// cycles before a port counts as stuck

	// one row of the stimulus table
	typedef struct packed
	{
		logic        isFetch;	// 0 data port, 1 fetch port
		memOpm_e     opm;
		logic [31:0] addr;
		logic [31:0] data;	// store data
		memOk_e      expOk;
		logic        mustHit;	// answer due in the first cycle
		logic        withNext;	// start together with the next row
	} testEntry_s;

	logic        clock;
	logic        rst;
	dataReq_s    dReq;
	dataResp_s   dResp;
	logic [31:0] fetchPc;
	fetchResp_s  fetchResp;

	logic        dArmed;
	logic        fArmed;
	dataResp_s   dExp;
	fetchResp_s  fExp;
	logic        dMustHit;
	logic        fMustHit;
	int          dTestNum;
	int          fTestNum;
	int          passCount;
	int          failCount;
	logic        timedOut;

	testEntry_s  testTable [$];
	logic [31:0] model [1024];	// word model of the low 4 KB
	logic [16:0] lfsr = 17'd98503;

	clockGen u_clockGen (.clock(clock), .rst(rst));

	memSubsys #(
		.numLines   (16),
		.memLines   (256),
		.memLatency (3)
	) u_memSubsys (
		.clock     (clock),
		.rst       (rst),
		.dReq      (dReq),
		.dResp     (dResp),
		.fetchPc   (fetchPc),
		.fetchResp (fetchResp)
	);

	memChecker u_memChecker (
		.clock     (clock),
		.rst       (rst),
		.dResp     (dResp),
		.fetchResp (fetchResp),
		.dArmed    (dArmed),
		.dExp      (dExp),
		.dMustHit  (dMustHit),
		.dTestNum  (dTestNum),
		.fArmed    (fArmed),
		.fExp      (fExp),
		.fMustHit  (fMustHit),
		.fTestNum  (fTestNum),
		.passCount (passCount),
		.failCount (failCount)
	);

	// power-on word, address xor fixed pattern
	function automatic logic [31:0] seedWord(input logic [31:0] byteAddr);
		return byteAddr ^ 32'h5A5A0000;
	endfunction

	// 17-bit fibonacci lfsr, taps 17 and 14
	function automatic logic nextBit();
		logic fb;
		fb   = lfsr[16] ^ lfsr[13];
		lfsr = {lfsr[15:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], nextBit()};	// one step per bit
		return v;
	endfunction

	function automatic logic [15:0] expectedHalf(input logic [31:0] addr);
		logic [31:0] word;
		word = model[addr[11:2]];
		return addr[1] ? word[31:16] : word[15:0];	// upper half at addr bit 1
	endfunction

	task automatic addEntry(input bit isFetch, input memOpm_e opm, input logic [31:0] addr,
		input logic [31:0] data, input memOk_e expOk, input bit mustHit, input bit withNext);
		testTable.push_back(testEntry_s'{isFetch, opm, addr, data, expOk, mustHit, withNext});
	endtask

	task automatic buildTable();
		logic [31:0] bits;
		logic [31:0] addr;
		logic        isStore;
		addEntry(0, opmReady, 0, 0, okReady, 1, 1);	// idle after reset
		addEntry(1, opmReady, 0, 0, okReady, 1, 0);
		addEntry(0, opmLoadWord, 32'h100, 0, okOk, 0, 0);	// cold miss
		addEntry(0, opmLoadWord, 32'h104, 0, okOk, 1, 0);	// same line hits
		addEntry(0, opmLoadWord, 32'h100, 0, okOk, 1, 0);
		addEntry(0, opmStoreWord, 32'h108, 32'hDEADBEEF, okOk, 0, 0);
		addEntry(0, opmLoadWord, 32'h108, 0, okOk, 1, 0);
		addEntry(0, opmLoadWord, 32'h10C, 0, okOk, 1, 0);	// untouched neighbour
		addEntry(0, opmStoreWord, 32'h100, 32'h12345678, okOk, 0, 0);
		addEntry(0, opmLoadWord, 32'h108, 0, okOk, 1, 0);	// earlier stored neighbour
		addEntry(0, opmLoadWord, 32'h100, 0, okOk, 1, 0);
		addEntry(0, opmStoreWord, 32'h204, 32'hCAFEF00D, okOk, 0, 0);	// store miss allocates
		addEntry(0, opmLoadWord, 32'h200, 0, okOk, 1, 0);
		addEntry(0, opmLoadWord, 32'h204, 0, okOk, 1, 0);
		addEntry(1, opmFetchHalf, 32'h102, 0, okOk, 0, 0);	// line written by data side
		addEntry(1, opmFetchHalf, 32'h10A, 0, okOk, 1, 0);
		addEntry(1, opmFetchHalf, 32'h10C, 0, okOk, 1, 0);
		addEntry(1, opmFetchHalf, 32'h300, 0, okOk, 0, 0);	// cold line
		addEntry(1, opmFetchHalf, 32'h30E, 0, okOk, 1, 0);
		addEntry(1, opmFetchHalf, 32'h904, 0, okOk, 0, 1);	// both ports miss at once
		addEntry(0, opmLoadWord, 32'h4A8, 0, okOk, 0, 0);
		addEntry(0, opmStoreWord, 32'h4B0, 32'h0BADC0DE, okOk, 0, 1);
		addEntry(1, opmFetchHalf, 32'hA12, 0, okOk, 0, 0);
		addEntry(1, opmFetchHalf, 32'hB06, 0, okOk, 0, 1);
		addEntry(0, opmStoreWord, 32'h4B4, 32'h600DF00D, okOk, 0, 0);
		addEntry(0, opmLoadWord, 32'h101, 0, okFault, 1, 0);	// misaligned
		addEntry(0, opmLoadWord, 32'h102, 0, okFault, 1, 0);
		addEntry(0, opmStoreWord, 32'h106, 32'hFFFFFFFF, okFault, 1, 0);
		addEntry(1, opmFetchHalf, 32'h303, 0, okFault, 1, 0);
		for (int i = 0; i < 12; i++)
		begin
			bits    = takeBits(1);
			isStore = bits[0];
			bits    = takeBits(9);
			addr    = bits << 2;	// words below 0x800
			if (isStore)
				addEntry(0, opmStoreWord, addr, takeBits(32), okOk, 0, 0);
			else
				addEntry(0, opmLoadWord, addr, 0, okOk, 0, 0);
		end
		for (int i = 0; i < 6; i++)
		begin
			bits = takeBits(10);
			addr = 32'h800 | (bits << 1);	// fetch region never stored
			addEntry(1, opmFetchHalf, addr, 0, okOk, 0, 0);
		end
	endtask

	task automatic dataRequest(input testEntry_s e, input int num);
		int cycles;
		cycles    = 0;
		dReq.opm  = e.opm;
		dReq.addr = e.addr;
		dReq.data = e.data;
		dExp.ok   = e.expOk;
		dExp.data = (e.opm == opmStoreWord) ? e.data : model[e.addr[11:2]];
		dMustHit  = e.mustHit;
		dTestNum  = num;
		dArmed    = 1'b1;
		if (e.opm == opmStoreWord && e.expOk == okOk)
			model[e.addr[11:2]] = e.data;
		@(posedge clock);
		while (dResp.ok == okHold && cycles < waitLimit)
		begin
			@(posedge clock);
			cycles++;
		end
		if (dResp.ok == okHold)
		begin
			$display("data port still waiting after %0d cycles on test %0d", waitLimit, num);
			timedOut = 1'b1;
		end
		@(negedge clock);
		dArmed = 1'b0;
		dReq   = '0;	// back to idle
	endtask

	task automatic fetchRequest(input testEntry_s e, input int num);
		int cycles;
		cycles   = 0;
		fetchPc  = (e.opm == opmReady) ? 32'h0 : e.addr;	// zero parks the port
		fExp.ok  = e.expOk;
		fExp.val = expectedHalf(e.addr);
		fMustHit = e.mustHit;
		fTestNum = num;
		fArmed   = 1'b1;
		@(posedge clock);
		while (fetchResp.ok == okHold && cycles < waitLimit)
		begin
			@(posedge clock);
			cycles++;
		end
		if (fetchResp.ok == okHold)
		begin
			$display("fetch port still waiting after %0d cycles on test %0d", waitLimit, num);
			timedOut = 1'b1;
		end
		@(negedge clock);
		fArmed  = 1'b0;
		fetchPc = 32'h0;
	endtask

	task automatic applyEntry(input testEntry_s e, input int num);
		if (e.isFetch)
			fetchRequest(e, num);
		else
			dataRequest(e, num);
	endtask

	initial
	begin
		int n;
		int waited;
		dReq     = '0;
		fetchPc  = 32'h0;
		dArmed   = 1'b0;
		fArmed   = 1'b0;
		dExp     = '0;
		fExp     = '0;
		dMustHit = 1'b0;
		fMustHit = 1'b0;
		dTestNum = 0;
		fTestNum = 0;
		timedOut = 1'b0;
		for (int i = 0; i < 1024; i++)
			model[i] = seedWord(32'(i * 4));
		buildTable();
		waited = 0;
		@(negedge clock);
		while (rst !== 1'b0 && waited < 20)
		begin
			@(negedge clock);
			waited++;
		end
		if (rst !== 1'b0)
		begin
			$display("reset never released");
			timedOut = 1'b1;
		end
		n = 0;
		while (n < testTable.size() && !timedOut)
		begin
			@(negedge clock);
			if (testTable[n].withNext && n + 1 < testTable.size())
			begin
				fork	// one row per port, same edge
					applyEntry(testTable[n], n);
					applyEntry(testTable[n + 1], n + 1);
				join
				n += 2;
			end
			else
			begin
				applyEntry(testTable[n], n);
				n++;
			end
		end
		repeat (2) @(negedge clock);
		$display("summary: %0d tests, %0d passed, %0d failed",
			testTable.size(), passCount, failCount);
		if (timedOut || failCount != 0 || passCount != testTable.size())
			$display("Test failed");
		else
			$display("Test passed");
		$finish;
	end

endmodule

//--- files.f
rtl/memSysPkg.sv
rtl/instCache.sv
rtl/dataCache.sv
rtl/lineArbiter.sv
rtl/lineMemory.sv
rtl/memSubsys.sv
dv/clockGen.sv
dv/memChecker.sv
dv/memSubsysTb.sv

//--- Makefile
TOP = memSubsysTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f files.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
